//--- project.f
source/cpuPkg.sv
source/cpuIf.sv
source/opcodeDecoder.sv
source/cycleSequencer.sv
source/interruptControl.sv
source/addressRegisters.sv
source/cpuCore.sv
dv/cpuCoreTb.sv

//--- Makefile
BUILD = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f project.f --top-module cpuCoreTb \
		-Mdir $(BUILD) -o cpuCoreTb

run: compile
	./$(BUILD)/cpuCoreTb > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

//--- dv/cpuCoreTb.sv
`timescale 1ns/1ps

module cpuCoreTb;

  localparam cpuPkg::addr_t nmiVector = cpuPkg::defaultNmiVector;
  localparam cpuPkg::addr_t intVector = cpuPkg::defaultIntVector;
  localparam int testClocks = 260;   // Summed lengths of all tests
  localparam int marginClocks = 240;

  logic clk;
  logic reset_n;
  logic waitN;
  logic intN;
  logic nmiN;
  logic busRqN;
  cpuPkg::data_t dataIn;
  cpuPkg::addr_t address;
  logic m1N;
  logic haltN;
  logic busAckN;
  logic intAckN;
  logic intEnable;
  cpuPkg::mCycle_t mCycle;
  cpuPkg::tState_t tState;

  cpuPkg::data_t mem [0:65535];
  string testName;
  int errors;

  // Reference model of the fetch sequence
  cpuPkg::addr_t expFetch;
  cpuPkg::addr_t ackVector;
  cpuPkg::data_t op;
  logic halted;
  logic ie;
  logic ieNext;
  logic ackNext;
  logic ackIsNmi;
  logic intAckCycle;
  logic reqSync;
  int nmiRequests;
  int nmiFired;
  int nmiLow;
  logic fetchStart;
  logic lastT;

  cpuCore #(
    .nmiVector (nmiVector),
    .intVector (intVector)
  ) uut (
    .clk       (clk),
    .reset_n   (reset_n),
    .waitN     (waitN),
    .intN      (intN),
    .nmiN      (nmiN),
    .busRqN    (busRqN),
    .dataIn    (dataIn),
    .address   (address),
    .m1N       (m1N),
    .haltN     (haltN),
    .busAckN   (busAckN),
    .intAckN   (intAckN),
    .intEnable (intEnable),
    .mCycle    (mCycle),
    .tState    (tState)
  );

  assign dataIn = mem[address];  // Program memory, no wait of its own
  assign fetchStart = (mCycle == cpuPkg::mcM1) && (tState == cpuPkg::tsT1);
  assign lastT = (mCycle == cpuPkg::mcM1) ? (tState == cpuPkg::tsT4)
                                          : (tState == cpuPkg::tsT3);

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic reportFail(input string what, input logic [31:0] exp, input logic [31:0] act);
    errors++;
    $display("CHECK FAILED %s (%s): expected %0h, actual %0h", testName, what, exp, act);
  endtask

  // ----------------------------------------
  // Model of fetch order, halt and acks
  // ----------------------------------------
  always @(posedge clk)
  begin
    if (!reset_n)
    begin
      expFetch    <= '0;
      ackVector   <= '0;
      halted      <= 1'b0;
      ie          <= 1'b0;
      ackNext     <= 1'b0;
      ackIsNmi    <= 1'b0;
      intAckCycle <= 1'b0;
      reqSync     <= 1'b0;
      nmiN        <= 1'b1;
      nmiFired    <= 0;
      nmiLow      <= 0;
    end
    else
    begin
      reqSync <= !busRqN;
      if (nmiLow > 1)
        nmiLow <= nmiLow - 1;
      else
        nmiN <= 1'b1;  // End of the nmi pulse
      if (fetchStart && ackNext)
      begin
        expFetch    <= ackVector;
        halted      <= 1'b0;
        ackNext     <= 1'b0;
        intAckCycle <= !ackIsNmi;
      end
      else if (fetchStart)
      begin
        intAckCycle <= 1'b0;
        op = halted ? cpuPkg::opNop : mem[expFetch];
        ieNext = (op == cpuPkg::opEi) ? 1'b1 : (op == cpuPkg::opDi) ? 1'b0 : ie;
        ie <= ieNext;
        if (op == cpuPkg::opJp)
          expFetch <= {mem[expFetch + 16'd2], mem[expFetch + 16'd1]};
        else if (op == cpuPkg::opHalt)
        begin
          expFetch <= expFetch + 16'd1;
          halted   <= 1'b1;
        end
        else if (!halted)
          expFetch <= expFetch + 16'd1;
        // Nmi pulse starts here, so it is taken when this instruction ends
        if (nmiRequests != nmiFired)
        begin
          nmiFired  <= nmiFired + 1;
          nmiN      <= 1'b0;
          nmiLow    <= 3;
          ackNext   <= 1'b1;
          ackIsNmi  <= 1'b1;
          ackVector <= nmiVector;
          ie        <= 1'b0;
        end
        else if (ieNext && !intN && op != cpuPkg::opEi)
        begin
          ackNext   <= 1'b1;
          ackIsNmi  <= 1'b0;
          ackVector <= intVector;
          ie        <= 1'b0;
        end
      end
    end
  end

  // ----------------------------------------
  // Checks
  // ----------------------------------------
  resetOutputs: assert property (@(posedge clk) !reset_n |=>
      {m1N, haltN, busAckN, intAckN, intEnable} == 5'b11110)
    else reportFail("reset outputs", 5'b11110,
                    $sampled({m1N, haltN, busAckN, intAckN, intEnable}));
  resetState: assert property (@(posedge clk) !reset_n |=>
      address == 16'h0000 && fetchStart)
    else reportFail("reset address", 0, $sampled(address));
  fetchAddress: assert property (@(posedge clk) disable iff (!reset_n)
      fetchStart |-> address == expFetch)
    else reportFail("fetch address", $sampled(expFetch), $sampled(address));
  t1Length: assert property (@(posedge clk) disable iff (!reset_n)
      tState == cpuPkg::tsT1 |=> tState == cpuPkg::tsT2)
    else reportFail("T1 to T2", cpuPkg::tsT2, $sampled(tState));
  t2Length: assert property (@(posedge clk) disable iff (!reset_n)
      tState == cpuPkg::tsT2 && waitN |=> tState == cpuPkg::tsT3)
    else reportFail("T2 to T3", cpuPkg::tsT3, $sampled(tState));
  waitHold: assert property (@(posedge clk) disable iff (!reset_n)
      tState == cpuPkg::tsT2 && !waitN |=> tState == cpuPkg::tsT2 && $stable(address))
    else reportFail("wait hold", cpuPkg::tsT2, $sampled(tState));
  m1T4: assert property (@(posedge clk) disable iff (!reset_n)
      mCycle == cpuPkg::mcM1 && tState == cpuPkg::tsT3 |=> tState == cpuPkg::tsT4)
    else reportFail("M1 has T4", cpuPkg::tsT4, $sampled(tState));
  cycleEnd: assert property (@(posedge clk) disable iff (!reset_n)
      lastT && !reqSync |=> tState == cpuPkg::tsT1)
    else reportFail("cycle end", cpuPkg::tsT1, $sampled(tState));
  busPark: assert property (@(posedge clk) disable iff (!reset_n)
      lastT && reqSync |=> !busAckN && $stable(tState) && $stable(mCycle))
    else reportFail("bus park", 0, $sampled(busAckN));
  busRelease: assert property (@(posedge clk) disable iff (!reset_n)
      !reqSync |=> busAckN)
    else reportFail("bus release", 1, $sampled(busAckN));
  busFrozen: assert property (@(posedge clk) disable iff (!reset_n)
      !busAckN |=> busAckN || $stable(address))
    else reportFail("address frozen", $past(address), $sampled(address));
  m1Low: assert property (@(posedge clk) disable iff (!reset_n)
      mCycle == cpuPkg::mcM1 && tState == cpuPkg::tsT2 |-> !m1N)
    else reportFail("m1N in T2", 0, $sampled(m1N));
  m1High: assert property (@(posedge clk) disable iff (!reset_n)
      tState == cpuPkg::tsT3 || tState == cpuPkg::tsT4 |-> m1N)
    else reportFail("m1N after T2", 1, $sampled(m1N));
  haltPin: assert property (@(posedge clk) disable iff (!reset_n)
      fetchStart |-> haltN == !(halted && !ackNext))
    else reportFail("haltN", $sampled(!(halted && !ackNext)), $sampled(haltN));
  ackStart: assert property (@(posedge clk) disable iff (!reset_n)
      fetchStart |-> intAckN == !(ackNext && !ackIsNmi))
    else reportFail("intAckN at T1", $sampled(!(ackNext && !ackIsNmi)), $sampled(intAckN));
  ackBody: assert property (@(posedge clk) disable iff (!reset_n)
      !fetchStart |-> intAckN == !intAckCycle)
    else reportFail("intAckN in cycle", $sampled(!intAckCycle), $sampled(intAckN));
  enableFlop: assert property (@(posedge clk) disable iff (!reset_n)
      fetchStart |-> intEnable == ie)
    else reportFail("intEnable", $sampled(ie), $sampled(intEnable));

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  task automatic waitForFetch(input cpuPkg::addr_t target);
    do
      @(posedge clk);
    while (!(fetchStart && address == target));
  endtask

  task automatic insertWaitStates();
    int unsigned len;
    len = 1 + ($urandom % 6);
    do
      @(posedge clk);
    while (tState != cpuPkg::tsT1);
    waitN <= 1'b0;  // Low from T2 on
    repeat (len) @(posedge clk);
    waitN <= 1'b1;
  endtask

  initial
  begin
    for (int a = 0; a < 65536; a++)
      mem[a] = (a[15:8] ^ a[7:0]) & 8'h3F;  // Never HALT, DI, EI or JP
    mem[16'h0000] = cpuPkg::opNop;
    mem[16'h0001] = cpuPkg::opNop;
    mem[16'h0002] = cpuPkg::opJp;
    mem[16'h0003] = 8'h10;
    mem[16'h0004] = 8'h00;
    mem[16'h0010] = cpuPkg::opEi;
    mem[16'h0011] = cpuPkg::opDi;
    mem[16'h0030] = cpuPkg::opHalt;
    mem[16'h0066] = cpuPkg::opNop;
    mem[16'h0067] = cpuPkg::opEi;
    mem[16'h0068] = cpuPkg::opNop;
    void'($urandom(97));
    errors = 0;
    nmiRequests = 0;
    testName = "reset";
    reset_n = 1'b0;
    waitN = 1'b1;
    intN = 1'b1;
    nmiN = 1'b1;
    busRqN = 1'b1;
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;

    testName = "nop and jp";
    waitForFetch(16'h0010);

    testName = "wait states";
    repeat (3) insertWaitStates();

    testName = "bus request";
    busRqN <= 1'b0;
    do
      @(posedge clk);
    while (busAckN);
    repeat (4) @(posedge clk);
    busRqN <= 1'b1;
    do
      @(posedge clk);
    while (!busAckN);

    testName = "halt and nmi";
    intN <= 1'b0;  // Held while DI is in effect, through halt and nmi
    do
      @(posedge clk);
    while (haltN);
    repeat (6) @(posedge clk);
    nmiRequests <= nmiRequests + 1;
    waitForFetch(nmiVector);

    testName = "maskable interrupt";
    waitForFetch(intVector);
    intN <= 1'b1;
    repeat (12) @(posedge clk);

    $display("Run complete, %0d errors", errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  initial
  begin
    repeat (testClocks + marginClocks) @(posedge clk);
    $display("Timeout in %s, the core stopped making progress", testName);
    $display("Finished with errors");
    $finish;
  end

endmodule

//--- source/cpuCore.sv
`timescale 1ns/1ps

module cpuCore #(
  parameter cpuPkg::addr_t nmiVector = cpuPkg::defaultNmiVector,
  parameter cpuPkg::addr_t intVector = cpuPkg::defaultIntVector
) (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            waitN,
  input  logic            intN,
  input  logic            nmiN,
  input  logic            busRqN,
  input  cpuPkg::data_t   dataIn,
  output cpuPkg::addr_t   address,
  output logic            m1N,
  output logic            haltN,
  output logic            busAckN,
  output logic            intAckN,
  output logic            intEnable,
  output cpuPkg::mCycle_t mCycle,
  output cpuPkg::tState_t tState
);

  decodeIf decBus ();
  cycleIf  cycBus ();

  cpuPkg::data_t opcode;
  logic          acceptNmi;
  logic          acceptInt;
  logic          busReqSync;

  opcodeDecoder decoder (
    .opcode (opcode),
    .cyc    (cycBus),
    .dec    (decBus)
  );

  cycleSequencer sequencer (
    .clk        (clk),
    .reset_n    (reset_n),
    .waitN      (waitN),
    .busReqSync (busReqSync),
    .acceptNmi  (acceptNmi),
    .acceptInt  (acceptInt),
    .dec        (decBus),
    .cyc        (cycBus),
    .m1N        (m1N),
    .haltN      (haltN),
    .busAckN    (busAckN),
    .intAckN    (intAckN)
  );

  interruptControl interrupts (
    .clk        (clk),
    .reset_n    (reset_n),
    .intN       (intN),
    .nmiN       (nmiN),
    .busRqN     (busRqN),
    .dec        (decBus),
    .cyc        (cycBus),
    .acceptNmi  (acceptNmi),
    .acceptInt  (acceptInt),
    .busReqSync (busReqSync),
    .intEnable  (intEnable)
  );

  addressRegisters #(
    .nmiVector (nmiVector),
    .intVector (intVector)
  ) addrRegs (
    .clk     (clk),
    .reset_n (reset_n),
    .dataIn  (dataIn),
    .dec     (decBus),
    .cyc     (cycBus),
    .opcode  (opcode),
    .address (address)
  );

  // Cycle timing visible on the pins
  assign mCycle = cycBus.mCycle;
  assign tState = cycBus.tState;

endmodule

//--- source/addressRegisters.sv
`timescale 1ns/1ps

module addressRegisters #(
  parameter cpuPkg::addr_t nmiVector = cpuPkg::defaultNmiVector,
  parameter cpuPkg::addr_t intVector = cpuPkg::defaultIntVector
) (
  input  logic          clk,
  input  logic          reset_n,
  input  cpuPkg::data_t dataIn,
  decodeIf.sink         dec,
  cycleIf.sink          cyc,
  output cpuPkg::data_t opcode,
  output cpuPkg::addr_t address
);

  cpuPkg::addr_t pc;
  cpuPkg::addr_t tmpAddr;
  cpuPkg::addr_t nextAddr;
  logic          ackCycle;
  logic          jumpEnd;

  assign ackCycle = cyc.intCycle || cyc.nmiCycle;
  assign jumpEnd  = dec.jump && (cyc.mCycle == cpuPkg::mcM3);

  // ----------------------------------------
  // Address of the next machine cycle
  // ----------------------------------------
  always_comb
  begin
    if (cyc.nmiCycle)
      nextAddr = nmiVector;
    else if (cyc.intCycle)
      nextAddr = intVector;
    else if (jumpEnd)
      nextAddr = tmpAddr;
    else if (cyc.mCycle == cpuPkg::mcM2)
      nextAddr = pc + 1'b1;  // High operand byte
    else
      nextAddr = pc;
  end

  // Loads at tRes repeat harmlessly while the bus is granted away,
  // so the parked address is already the next cycle's
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      pc      <= '0;
      address <= '0;
      opcode  <= cpuPkg::opNop;
    end
    else
    begin
      if (cyc.fetchDone)
      begin
        opcode <= dataIn;
        pc     <= pc + 1'b1;
      end
      if (cyc.tRes)
      begin
        address <= nextAddr;
        if (ackCycle || jumpEnd)
          pc <= nextAddr;
      end
    end
  end

  // ----------------------------------------
  // JP operand, sampled through T2
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (cyc.tState == cpuPkg::tsT2 && cyc.mCycle == cpuPkg::mcM2)
      tmpAddr[7:0] <= dataIn;
    if (cyc.tState == cpuPkg::tsT2 && cyc.mCycle == cpuPkg::mcM3)
      tmpAddr[15:8] <= dataIn;  // Last write is the one where waitN let go
  end

endmodule

//--- source/interruptControl.sv
`timescale 1ns/1ps

module interruptControl (
  input  logic  clk,
  input  logic  reset_n,
  input  logic  intN,
  input  logic  nmiN,
  input  logic  busRqN,
  decodeIf.sink dec,
  cycleIf.sink  cyc,
  output logic  acceptNmi,
  output logic  acceptInt,
  output logic  busReqSync,
  output logic  intEnable
);

  logic intReq;
  logic nmiSyncN;
  logic nmiPrevN;
  logic nmiLatch;
  logic iff1;
  logic iff2;
  logic decodeSlot;

  // ----------------------------------------
  // Input synchronizers
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      intReq     <= 1'b0;
      busReqSync <= 1'b0;
      nmiSyncN   <= 1'b1;  // Idle high so reset gives no false edge
      nmiPrevN   <= 1'b1;
    end
    else
    begin
      intReq     <= !intN;
      busReqSync <= !busRqN;
      nmiSyncN   <= nmiN;
      nmiPrevN   <= nmiSyncN;
    end
  end

  // Nmi is edge triggered, held until its acknowledge cycle starts
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      nmiLatch <= 1'b0;
    else if (cyc.instrEnd && acceptNmi)
      nmiLatch <= 1'b0;
    else if (nmiPrevN && !nmiSyncN)
      nmiLatch <= 1'b1;
  end

  // ----------------------------------------
  // Interrupt enable flip-flops
  // ----------------------------------------
  assign decodeSlot = (cyc.mCycle == cpuPkg::mcM1) && (cyc.tState == cpuPkg::tsT3);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      iff1 <= 1'b0;
      iff2 <= 1'b0;
    end
    else if (cyc.instrEnd && acceptNmi)
    begin
      iff1 <= 1'b0;  // iff2 keeps the state from before the nmi
    end
    else if (cyc.instrEnd && acceptInt)
    begin
      iff1 <= 1'b0;
      iff2 <= 1'b0;
    end
    else if (decodeSlot && dec.setEi)
    begin
      iff1 <= 1'b1;
      iff2 <= 1'b1;
    end
    else if (decodeSlot && dec.setDi)
    begin
      iff1 <= 1'b0;
      iff2 <= 1'b0;
    end
  end

  assign acceptNmi = nmiLatch;
  // EI holds off a request for one more instruction
  assign acceptInt = iff1 && iff2 && intReq && !nmiLatch && !dec.setEi;
  assign intEnable = iff1;

endmodule

//--- source/cycleSequencer.sv
`timescale 1ns/1ps

module cycleSequencer (
  input  logic    clk,
  input  logic    reset_n,
  input  logic    waitN,
  input  logic    busReqSync,
  input  logic    acceptNmi,
  input  logic    acceptInt,
  decodeIf.sink   dec,
  cycleIf.source  cyc,
  output logic    m1N,
  output logic    haltN,
  output logic    busAckN,
  output logic    intAckN
);

  cpuPkg::mCycle_t mCycle;
  cpuPkg::tState_t tState;
  logic            haltState;
  logic            busAck;
  logic            intCycle;
  logic            nmiCycle;
  logic            lastT;
  logic            lastM;
  logic            waiting;
  logic            cycleEnd;

  // ----------------------------------------
  // End of cycle detection
  // ----------------------------------------
  always_comb
  begin
    if (mCycle == cpuPkg::mcM1)
      lastT = (tState == cpuPkg::tsT4);
    else
      lastT = (tState == cpuPkg::tsT3);

    case (dec.mCycles)
      2'd3:    lastM = (mCycle == cpuPkg::mcM3);
      2'd2:    lastM = (mCycle == cpuPkg::mcM2);
      default: lastM = (mCycle == cpuPkg::mcM1);
    endcase
  end

  assign waiting  = (tState == cpuPkg::tsT2) && !waitN;
  assign cycleEnd = lastT && !busReqSync;  // A bus request parks us at the boundary

  // ----------------------------------------
  // T-state and machine-cycle FSM
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      mCycle    <= cpuPkg::mcM1;
      tState    <= cpuPkg::tsT1;
      haltState <= 1'b0;
      busAck    <= 1'b0;
      intCycle  <= 1'b0;
      nmiCycle  <= 1'b0;
      m1N       <= 1'b1;
    end
    else
    begin
      busAck <= lastT && busReqSync;

      if (cycleEnd)
      begin
        tState <= cpuPkg::tsT1;
        if (lastM)
        begin
          mCycle   <= cpuPkg::mcM1;
          m1N      <= 1'b0;
          nmiCycle <= acceptNmi;   // Nmi already has priority in acceptInt
          intCycle <= acceptInt;
          // Any accepted interrupt wakes the core
          haltState <= dec.halt && !(acceptNmi || acceptInt);
        end
        else
        begin
          mCycle <= mCycle << 1;
        end
      end
      else if (!lastT && !waiting)
      begin
        tState <= tState << 1;
      end

      // m1 strobe over T1 and T2 of every M1
      if (mCycle == cpuPkg::mcM1 && tState == cpuPkg::tsT1)
        m1N <= 1'b0;
      else if (mCycle == cpuPkg::mcM1 && tState == cpuPkg::tsT2 && waitN)
        m1N <= 1'b1;
    end
  end

  assign cyc.mCycle    = mCycle;
  assign cyc.tState    = tState;
  assign cyc.tRes      = lastT;
  assign cyc.instrEnd  = cycleEnd && lastM;
  assign cyc.intCycle  = intCycle;
  assign cyc.nmiCycle  = nmiCycle;

  // No opcode read while halted or acknowledging
  assign cyc.fetchDone = (mCycle == cpuPkg::mcM1) && (tState == cpuPkg::tsT2) && waitN
                         && !haltState && !intCycle && !nmiCycle;

  assign haltN   = !haltState;
  assign busAckN = !busAck;
  assign intAckN = !intCycle;  // Maskable acknowledge only

endmodule

//--- source/opcodeDecoder.sv
`timescale 1ns/1ps

module opcodeDecoder (
  input  cpuPkg::data_t opcode,
  cycleIf.sink          cyc,
  decodeIf.source       dec
);

  always_comb
  begin
    dec.mCycles = 2'd1;
    dec.jump    = 1'b0;
    dec.halt    = 1'b0;
    dec.setEi   = 1'b0;
    dec.setDi   = 1'b0;

    // Acknowledge cycles see a plain one-cycle fetch, whatever the
    // opcode register still holds from the interrupted instruction
    if (!cyc.intCycle && !cyc.nmiCycle)
    begin
      case (opcode)
        cpuPkg::opJp:
        begin
          dec.mCycles = 2'd3;  // Fetch, low byte, high byte
          dec.jump    = 1'b1;
        end
        cpuPkg::opHalt:
        begin
          dec.halt = 1'b1;
        end
        cpuPkg::opEi:
        begin
          dec.setEi = 1'b1;
        end
        cpuPkg::opDi:
        begin
          dec.setDi = 1'b1;
        end
        cpuPkg::opNop:
        begin
          dec.mCycles = 2'd1;
        end
        default:
        begin
          dec.mCycles = 2'd1;  // Unknown opcodes run as NOP
        end
      endcase
    end
  end

endmodule

//--- source/cpuIf.sv
`timescale 1ns/1ps

// Decoded controls for the opcode in the opcode register
interface decodeIf;
  logic [1:0] mCycles;  // 1 to 3
  logic       jump;
  logic       halt;
  logic       setEi;
  logic       setDi;

  modport source (output mCycles, jump, halt, setEi, setDi);
  modport sink   (input  mCycles, jump, halt, setEi, setDi);
endinterface

// Cycle timing from the sequencer
interface cycleIf;
  cpuPkg::mCycle_t mCycle;
  cpuPkg::tState_t tState;
  logic            tRes;       // Last T-state, stays high through a bus stall
  logic            fetchDone;  // Opcode register loads this clock
  logic            instrEnd;   // Last machine cycle ends this clock
  logic            intCycle;
  logic            nmiCycle;

  modport source (
    output mCycle, tState, tRes, fetchDone, instrEnd, intCycle, nmiCycle
  );
  modport sink (
    input  mCycle, tState, tRes, fetchDone, instrEnd, intCycle, nmiCycle
  );
endinterface

//--- source/cpuPkg.sv
package cpuPkg;

  // ----------------------------------------
  // Bus widths and word types
  // ----------------------------------------
  localparam int addrWidth = 16;
  localparam int dataWidth = 8;

  typedef logic [addrWidth-1:0] addr_t;
  typedef logic [dataWidth-1:0] data_t;

  // ----------------------------------------
  // One-hot cycle timing
  // ----------------------------------------
  localparam int tStateCount = 4;
  localparam int mCycleCount = 3;

  typedef logic [tStateCount-1:0] tState_t;
  typedef logic [mCycleCount-1:0] mCycle_t;

  localparam tState_t tsT1 = 4'b0001;
  localparam tState_t tsT2 = 4'b0010;
  localparam tState_t tsT3 = 4'b0100;
  localparam tState_t tsT4 = 4'b1000;  // M1 only

  localparam mCycle_t mcM1 = 3'b001;   // Opcode fetch
  localparam mCycle_t mcM2 = 3'b010;
  localparam mCycle_t mcM3 = 3'b100;

  // ----------------------------------------
  // Opcodes handled by the decoder
  // ----------------------------------------
  localparam data_t opNop  = 8'h00;
  localparam data_t opHalt = 8'h76;
  localparam data_t opDi   = 8'hF3;
  localparam data_t opEi   = 8'hFB;
  localparam data_t opJp   = 8'hC3;    // JP nn, low byte first

  // Restart addresses for the acknowledge cycles
  localparam addr_t defaultNmiVector = 16'h0066;
  localparam addr_t defaultIntVector = 16'h0038;  // Mode 1 only

endpackage
